/* cache_defs.svh */
// --------------------
// Geometry of the data cache, shared by the packages and the RTL.
// Include this file wherever a width or a count is needed.
// --------------------
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

`define CACHE_ADDR_W      32
`define CACHE_WAYS        4
`define CACHE_SETS        8
`define CACHE_LINE_WORDS  8
`define CACHE_WORD_W      32

// Field widths of a byte address.
`define CACHE_BYTE_OFF_W  ($clog2(`CACHE_WORD_W / 8))
`define CACHE_OFF_W       ($clog2(`CACHE_LINE_WORDS))
`define CACHE_INDEX_W     ($clog2(`CACHE_SETS))
`define CACHE_TAG_W       (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFF_W - `CACHE_BYTE_OFF_W)
`define CACHE_WAY_W       ($clog2(`CACHE_WAYS))

`endif

/* cache_geom_pkg.sv */
// --------------------
// Vector types for address fields, ways, ages and line data.
// --------------------
`include "cache_defs.svh"

package cache_geom_pkg;

    // Address and its fields.
    typedef logic [`CACHE_ADDR_W-1:0]     addr_t;
    typedef logic [`CACHE_TAG_W-1:0]      tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]    index_t;
    typedef logic [`CACHE_OFF_W-1:0]      word_off_t;

    // Way number and LRU age, 0 is least recent.
    typedef logic [`CACHE_WAY_W-1:0]      way_t;
    typedef logic [`CACHE_WAY_W-1:0]      age_t;

    // Data.
    typedef logic [`CACHE_WORD_W-1:0]     word_t;
    typedef logic [`CACHE_WORD_W/8-1:0]   strb_t;
    typedef logic [`CACHE_LINE_WORDS*`CACHE_WORD_W-1:0] block_t;

endpackage

/* cache_bus_pkg.sv */
// --------------------
// Bundles at the cache ports and the internal access kind.
// --------------------
package cache_bus_pkg;

    // APB request from the processor side.
    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        cache_geom_pkg::addr_t  paddr;
        cache_geom_pkg::word_t  pwdata;
        cache_geom_pkg::strb_t  pstrb;
    } apb_req_t;

    // Refill request, held until accepted.
    typedef struct packed {
        logic                   valid;
        cache_geom_pkg::addr_t  addr;
        cache_geom_pkg::block_t block;
    } fill_req_t;

    // Victim line report for write-back.
    typedef struct packed {
        logic                   dirty;
        cache_geom_pkg::tag_t   tag;
        cache_geom_pkg::block_t block;
    } evict_t;

    // What the arrays do on the next edge.
    typedef enum logic [1:0] {
        ACC_NONE,
        ACC_READ,
        ACC_WRITE,
        ACC_FILL
    } access_e;

endpackage

/* cache_tag_store.sv */
// --------------------
// Tag, valid and dirty arrays with hit detection.
// Also reports the dirty bit and tag of the victim way.
// --------------------
`include "cache_defs.svh"

module cache_tag_store (
    input  logic                      clk,
    input  logic                      arstn,
    input  cache_bus_pkg::access_e    i_access,
    input  cache_geom_pkg::index_t    i_index,
    input  cache_geom_pkg::tag_t      i_tag,
    input  cache_geom_pkg::way_t      i_hit_way,
    input  cache_geom_pkg::way_t      i_victim,
    output logic                      o_hit,
    output cache_geom_pkg::way_t      o_hit_way,
    output logic                      o_victim_dirty,
    output cache_geom_pkg::tag_t      o_victim_tag
);
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    tag_t                    tag_mem [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0]  valid_q [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0]  dirty_q [`CACHE_SETS];

    // Lowest matching way wins.
    always_comb begin
        o_hit     = 1'b0;
        o_hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!o_hit && valid_q[i_index][w] && (tag_mem[i_index][w] == i_tag)) begin
                o_hit     = 1'b1;
                o_hit_way = way_t'(w);
            end
        end
    end

    assign o_victim_dirty = dirty_q[i_index][i_victim];
    assign o_victim_tag   = tag_mem[i_index][i_victim];

    always_ff @(posedge clk) begin
        if (i_access == ACC_FILL) begin
            tag_mem[i_index][i_victim] <= i_tag;
        end
    end

    // Fill installs a clean line, a write hit marks it dirty.
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (i_access == ACC_FILL) begin
            valid_q[i_index][i_victim] <= 1'b1;
            dirty_q[i_index][i_victim] <= 1'b0;
        end else if (i_access == ACC_WRITE) begin
            dirty_q[i_index][i_hit_way] <= 1'b1;
        end
    end

endmodule

/* cache_lru.sv */
// --------------------
// Age-based LRU per set; the age-0 way is the victim.
// --------------------
`include "cache_defs.svh"

module cache_lru (
    input  logic                    clk,
    input  logic                    arstn,
    input  cache_bus_pkg::access_e  i_access,
    input  cache_geom_pkg::index_t  i_index,
    input  cache_geom_pkg::way_t    i_hit_way,
    output cache_geom_pkg::way_t    o_victim
);
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    age_t  age_q [`CACHE_SETS][`CACHE_WAYS];
    way_t  s_target;
    age_t  s_target_age;

    // Ages in a set are a permutation, so exactly one is zero.
    always_comb begin
        o_victim = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (age_q[i_index][w] == '0) begin
                o_victim = way_t'(w);
            end
        end
    end

    // Way being promoted on this edge.
    assign s_target     = (i_access == ACC_FILL) ? o_victim : i_hit_way;
    assign s_target_age = age_q[i_index][s_target];

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    age_q[s][w] <= age_t'(w);
                end
            end
        end else if (i_access != ACC_NONE) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (way_t'(w) == s_target) begin
                    age_q[i_index][w] <= '1;
                end else if (age_q[i_index][w] > s_target_age) begin
                    // Younger ways move down one step.
                    age_q[i_index][w] <= age_q[i_index][w] - age_t'(1);
                end
            end
        end
    end

endmodule

/* cache_data_store.sv */
// --------------------
// Line data array with strobed word writes and block refill.
// Reads are combinational.
// --------------------
`include "cache_defs.svh"

module cache_data_store (
    input  logic                      clk,
    input  cache_bus_pkg::access_e    i_access,
    input  cache_geom_pkg::index_t    i_index,
    input  cache_geom_pkg::word_off_t i_word_off,
    input  cache_geom_pkg::way_t      i_hit_way,
    input  cache_geom_pkg::way_t      i_victim,
    input  cache_geom_pkg::word_t     i_wdata,
    input  cache_geom_pkg::strb_t     i_strb,
    input  cache_geom_pkg::block_t    i_block,
    output cache_geom_pkg::word_t     o_rdata,
    output cache_geom_pkg::block_t    o_victim_block
);
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    localparam int LANES = `CACHE_WORD_W / 8;

    block_t  data_mem [`CACHE_SETS][`CACHE_WAYS];

    // --------------------
    // Write port.
    // --------------------
    always_ff @(posedge clk) begin
        if (i_access == ACC_WRITE) begin
            for (int b = 0; b < LANES; b++) begin
                if (i_strb[b]) begin
                    data_mem[i_index][i_hit_way][i_word_off*`CACHE_WORD_W + b*8 +: 8]
                        <= i_wdata[b*8 +: 8];
                end
            end
        end else if (i_access == ACC_FILL) begin
            data_mem[i_index][i_victim] <= i_block;
        end
    end

    // --------------------
    // Read ports.
    // --------------------
    assign o_rdata        = data_mem[i_index][i_hit_way][i_word_off*`CACHE_WORD_W +: `CACHE_WORD_W];
    assign o_victim_block = data_mem[i_index][i_victim];

endmodule

/* cache_ctrl.sv */
// --------------------
// APB slave response and access arbitration.
// The APB access cycle always wins over a pending refill.
// --------------------
module cache_ctrl (
    input  cache_bus_pkg::apb_req_t  i_apb,
    input  logic                     i_fill_valid,
    input  logic                     i_hit,
    input  cache_geom_pkg::word_t    i_rdata,
    output cache_bus_pkg::access_e   o_access,
    output logic                     o_use_fill,
    output cache_geom_pkg::word_t    o_prdata,
    output logic                     o_pready,
    output logic                     o_pslverr,
    output logic                     o_fill_ready
);
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    logic s_access_phase;
    logic s_hit_access;

    // Second cycle of an APB transfer.
    assign s_access_phase = i_apb.psel & i_apb.penable;
    assign s_hit_access   = s_access_phase & i_hit;

    // Refill takes the arrays whenever APB does not need them.
    assign o_use_fill   = ~s_access_phase;
    assign o_fill_ready = i_fill_valid & ~s_access_phase;

    // --------------------
    // Response.
    // --------------------
    assign o_pready  = s_access_phase;
    assign o_pslverr = s_access_phase & ~i_hit;
    assign o_prdata  = (s_hit_access && !i_apb.pwrite) ? i_rdata : word_t'(0);

    // Kind of array update for this cycle.
    always_comb begin
        if (s_hit_access) begin
            o_access = i_apb.pwrite ? ACC_WRITE : ACC_READ;
        end else if (o_fill_ready) begin
            o_access = ACC_FILL;
        end else begin
            o_access = ACC_NONE;
        end
    end

endmodule

/* data_cache_top.sv */
// --------------------
// Top of the 4-way write-back data cache.
// APB slave for accesses, refill port and victim report for the outside.
// --------------------
`include "cache_defs.svh"

module data_cache_top (
    input  logic                      clk,
    input  logic                      arstn,
    input  cache_bus_pkg::apb_req_t   i_apb,
    input  cache_bus_pkg::fill_req_t  i_fill,
    output cache_geom_pkg::word_t     o_prdata,
    output logic                      o_pready,
    output logic                      o_pslverr,
    output logic                      o_fill_ready,
    output cache_bus_pkg::evict_t     o_evict
);
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    access_e    s_access;
    logic       s_use_fill;
    addr_t      s_addr;
    tag_t       s_tag;
    index_t     s_index;
    word_off_t  s_word_off;
    logic       s_hit;
    way_t       s_hit_way;
    way_t       s_victim;
    logic       s_victim_dirty;
    tag_t       s_victim_tag;
    block_t     s_victim_block;
    word_t      s_rdata;

    // --------------------
    // Address select and split.
    // --------------------
    assign s_addr     = s_use_fill ? i_fill.addr : i_apb.paddr;
    assign s_tag      = s_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign s_index    = s_addr[`CACHE_BYTE_OFF_W + `CACHE_OFF_W +: `CACHE_INDEX_W];
    assign s_word_off = s_addr[`CACHE_BYTE_OFF_W +: `CACHE_OFF_W];

    cache_ctrl u_ctrl (
        .i_apb        (i_apb),
        .i_fill_valid (i_fill.valid),
        .i_hit        (s_hit),
        .i_rdata      (s_rdata),
        .o_access     (s_access),
        .o_use_fill   (s_use_fill),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .o_fill_ready (o_fill_ready)
    );

    cache_tag_store u_tags (
        .clk            (clk),
        .arstn          (arstn),
        .i_access       (s_access),
        .i_index        (s_index),
        .i_tag          (s_tag),
        .i_hit_way      (s_hit_way),
        .i_victim       (s_victim),
        .o_hit          (s_hit),
        .o_hit_way      (s_hit_way),
        .o_victim_dirty (s_victim_dirty),
        .o_victim_tag   (s_victim_tag)
    );

    cache_lru u_lru (
        .clk       (clk),
        .arstn     (arstn),
        .i_access  (s_access),
        .i_index   (s_index),
        .i_hit_way (s_hit_way),
        .o_victim  (s_victim)
    );

    cache_data_store u_data (
        .clk            (clk),
        .i_access       (s_access),
        .i_index        (s_index),
        .i_word_off     (s_word_off),
        .i_hit_way      (s_hit_way),
        .i_victim       (s_victim),
        .i_wdata        (i_apb.pwdata),
        .i_strb         (i_apb.pstrb),
        .i_block        (i_fill.block),
        .o_rdata        (s_rdata),
        .o_victim_block (s_victim_block)
    );

    // Victim of the addressed set, for write-back by the outside.
    assign o_evict = '{dirty: s_victim_dirty, tag: s_victim_tag, block: s_victim_block};

endmodule

/* cache_assert.sv */
// --------------------
// Concurrent protocol checks, bound into data_cache_top by the testbench.
// --------------------
module cache_assert (
    input  logic                      clk,
    input  logic                      arstn,
    input  cache_bus_pkg::apb_req_t   i_apb,
    input  cache_bus_pkg::fill_req_t  i_fill,
    input  logic                      i_pready,
    input  logic                      i_pslverr,
    input  logic                      i_fill_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned n_fail = 0;
    logic        s_access;

    assign s_access = i_apb.psel && i_apb.penable;

    // Ready marks exactly the access cycle.
    a_pready_phase: assert property (@(posedge clk) disable iff (!arstn)
        i_pready == s_access)
    else begin
        n_fail++;
        $error("pready is not equal to the APB access phase");
    end

    // A refill is taken only while pending and with no APB access.
    a_fill_gate: assert property (@(posedge clk) disable iff (!arstn)
        i_fill_ready |-> (i_fill.valid && !s_access))
    else begin
        n_fail++;
        $error("fill_ready raised while no refill pending or APB in access phase");
    end

    a_err_in_access: assert property (@(posedge clk) disable iff (!arstn)
        i_pslverr |-> i_pready)
    else begin
        n_fail++;
        $error("pslverr raised outside an access cycle");
    end

endmodule

/* cache_checker.sv */
// --------------------
// Compares the DUT ports with the model expectations on every rising edge.
// Keeps per-test and total mismatch counts.
// --------------------
module cache_checker (
    input  logic                      clk,
    input  logic                      arstn,
    input  cache_bus_pkg::apb_req_t   i_apb,
    input  cache_bus_pkg::fill_req_t  i_fill,
    input  cache_geom_pkg::word_t     i_dut_prdata,
    input  logic                      i_dut_pready,
    input  logic                      i_dut_pslverr,
    input  logic                      i_dut_fill_ready,
    input  cache_bus_pkg::evict_t     i_dut_evict,
    input  logic                      i_exp_pslverr,
    input  cache_geom_pkg::word_t     i_exp_prdata,
    input  logic                      i_exp_line_valid,
    input  cache_bus_pkg::evict_t     i_exp_evict
);
    timeunit 1ns;
    timeprecision 1ps;
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    int unsigned n_errors = 0;
    int unsigned n_checks = 0;
    int unsigned n_tests  = 0;
    int unsigned n_failed = 0;
    int unsigned test_errors = 0;
    logic        s_access;
    logic        s_fill_ok;

    assign s_access  = i_apb.psel && i_apb.penable;
    assign s_fill_ok = i_fill.valid && !s_access;

    task automatic mismatch(input string msg);
        n_errors++;
        test_errors++;
        $display("MISMATCH t=%0t: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        if (arstn) begin
            n_checks++;
            if (i_dut_pready !== s_access)
                mismatch($sformatf("pready %b, expected %b", i_dut_pready, s_access));
            if (i_dut_fill_ready !== s_fill_ok)
                mismatch($sformatf("fill_ready %b, expected %b", i_dut_fill_ready, s_fill_ok));
            if (s_access) begin
                if (i_dut_pslverr !== i_exp_pslverr)
                    mismatch($sformatf("pslverr %b, expected %b", i_dut_pslverr, i_exp_pslverr));
                if (i_dut_prdata !== i_exp_prdata)
                    mismatch($sformatf("prdata %h, expected %h", i_dut_prdata, i_exp_prdata));
            end else if (i_dut_pslverr !== 1'b0 || i_dut_prdata !== '0) begin
                mismatch("pslverr or prdata not zero outside an access cycle");
            end
            // Victim report, tag and data only matter for a valid line.
            if (s_fill_ok) begin
                if (i_dut_evict.dirty !== i_exp_evict.dirty)
                    mismatch($sformatf("evict dirty %b, expected %b",
                                       i_dut_evict.dirty, i_exp_evict.dirty));
                if (i_exp_line_valid && i_dut_evict.tag !== i_exp_evict.tag)
                    mismatch($sformatf("evict tag %h, expected %h",
                                       i_dut_evict.tag, i_exp_evict.tag));
                if (i_exp_line_valid && i_dut_evict.block !== i_exp_evict.block)
                    mismatch("evict block differs from the model line");
            end
        end
    end

    task automatic end_test(input string name);
        n_tests++;
        if (test_errors == 0) begin
            $display("test %-10s passed", name);
        end else begin
            n_failed++;
            $display("test %-10s FAILED with %0d mismatches", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic report(input int unsigned n_assert_fail);
        $display("tests %0d, failed %0d, cycles checked %0d, mismatches %0d, assertion errors %0d",
                 n_tests, n_failed, n_checks, n_errors, n_assert_fail);
    endtask

endmodule

/* tb_data_cache.sv */
// --------------------
// Testbench for the data cache: seeded random APB traffic and refills,
// checked against a reference model of tags, ages and data.
// --------------------
`include "cache_defs.svh"

module tb_data_cache;
    timeunit 1ns;
    timeprecision 1ps;
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int RAND_OPS     = 2000;
    // Operations per test; a random op may add a refill.
    localparam int N_OPS = 21 + 9 + 28 + 9 + 13 + 2 * RAND_OPS;
    localparam int LIMIT = 6 * N_OPS + RESET_CYCLES;

    logic       clk;
    logic       arstn;
    apb_req_t   i_apb;
    fill_req_t  i_fill;
    word_t      o_prdata;
    logic       o_pready;
    logic       o_pslverr;
    logic       o_fill_ready;
    evict_t     o_evict;

    // Expectations for the checker.
    logic       exp_pslverr;
    word_t      exp_prdata;
    logic       exp_line_valid;
    evict_t     exp_evict;

    // Reference model.
    tag_t       m_tag   [`CACHE_SETS][`CACHE_WAYS];
    logic       m_valid [`CACHE_SETS][`CACHE_WAYS];
    logic       m_dirty [`CACHE_SETS][`CACHE_WAYS];
    age_t       m_age   [`CACHE_SETS][`CACHE_WAYS];
    block_t     m_data  [`CACHE_SETS][`CACHE_WAYS];
    tag_t       tag_pool [6];
    int unsigned cycles = 0;

    data_cache_top DUT (.*);

    cache_checker u_chk (
        .clk              (clk),
        .arstn            (arstn),
        .i_apb            (i_apb),
        .i_fill           (i_fill),
        .i_dut_prdata     (o_prdata),
        .i_dut_pready     (o_pready),
        .i_dut_pslverr    (o_pslverr),
        .i_dut_fill_ready (o_fill_ready),
        .i_dut_evict      (o_evict),
        .i_exp_pslverr    (exp_pslverr),
        .i_exp_prdata     (exp_prdata),
        .i_exp_line_valid (exp_line_valid),
        .i_exp_evict      (exp_evict)
    );

    bind data_cache_top cache_assert u_assert (
        .clk          (clk),
        .arstn        (arstn),
        .i_apb        (i_apb),
        .i_fill       (i_fill),
        .i_pready     (o_pready),
        .i_pslverr    (o_pslverr),
        .i_fill_ready (o_fill_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: the run went past %0d cycles", LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    // --------------------
    // Model rules.
    // --------------------
    function automatic addr_t make_addr(input tag_t tag, input index_t idx, input word_off_t off);
        return {tag, idx, off, 2'b00};
    endfunction

    function automatic way_t find_way(input index_t idx, input tag_t tag, output logic hit);
        way_t way;
        hit = 1'b0;
        way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                hit = 1'b1;
                way = way_t'(w);
            end
        end
        return way;
    endfunction

    // Least recent way has age 0.
    function automatic way_t lru_way(input index_t idx);
        way_t way;
        way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (m_age[idx][w] == 0) way = way_t'(w);
        end
        return way;
    endfunction

    function automatic void promote(input index_t idx, input way_t way);
        age_t old;
        old = m_age[idx][way];
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (w == way) m_age[idx][w] = 2'd3;
            else if (m_age[idx][w] > old) m_age[idx][w] = m_age[idx][w] - 2'd1;
        end
    endfunction

    function automatic block_t rand_block();
        block_t blk;
        for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
            blk[w*32 +: 32] = $urandom;
        end
        return blk;
    endfunction

    // --------------------
    // Drivers, called and returning at a falling edge.
    // --------------------
    task automatic apb_xfer(input logic wr, input tag_t tag, input index_t idx,
                            input word_off_t off, input word_t wdata, input strb_t strb,
                            output logic hit);
        way_t  way;
        word_t cur;
        i_apb = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: make_addr(tag, idx, off),
                  pwdata: wdata, pstrb: strb};
        @(negedge clk);
        i_apb.penable = 1'b1;
        way = find_way(idx, tag, hit);
        cur = m_data[idx][way][off*32 +: 32];
        exp_pslverr = !hit;
        exp_prdata  = (hit && !wr) ? cur : '0;
        @(posedge clk);
        if (hit) begin
            if (wr) begin
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) cur[b*8 +: 8] = wdata[b*8 +: 8];
                end
                m_data[idx][way][off*32 +: 32] = cur;
                m_dirty[idx][way] = 1'b1;
            end
            promote(idx, way);
        end
        @(negedge clk);
        i_apb.psel    = 1'b0;
        i_apb.penable = 1'b0;
    endtask

    // Holds the refill until the DUT takes it.
    task automatic refill(input tag_t tag, input index_t idx, input block_t blk);
        way_t vict;
        logic done;
        done = 1'b0;
        i_fill = '{valid: 1'b1, addr: make_addr(tag, idx, '0), block: blk};
        while (!done) begin
            vict = lru_way(idx);
            exp_line_valid = m_valid[idx][vict];
            exp_evict = '{dirty: m_dirty[idx][vict], tag: m_tag[idx][vict],
                          block: m_data[idx][vict]};
            @(posedge clk);
            if (o_fill_ready) begin
                done = 1'b1;
                m_tag[idx][vict]   = tag;
                m_valid[idx][vict] = 1'b1;
                m_dirty[idx][vict] = 1'b0;
                m_data[idx][vict]  = blk;
                promote(idx, vict);
            end
            @(negedge clk);
        end
        i_fill.valid = 1'b0;
    endtask

    // --------------------
    // Test sequence.
    // --------------------
    initial begin
        logic       hit;
        tag_t       tag;
        tag_t       tag_a;
        index_t     idx;
        void'($urandom(39308));
        arstn = 1'b0;
        i_apb = '0;
        i_fill = '0;
        exp_pslverr = 1'b0;
        exp_prdata = '0;
        exp_line_valid = 1'b0;
        exp_evict = '0;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                m_tag[s][w]   = '0;
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_age[s][w]   = age_t'(w);
                m_data[s][w]  = '0;
            end
        end
        // Low nibble keeps the pool tags distinct from each other and from tag_a.
        for (int k = 0; k < 6; k++) tag_pool[k] = {20'($urandom), 4'(k)};
        tag_a = {20'($urandom), 4'hf};
        repeat (RESET_CYCLES) @(negedge clk);
        arstn = 1'b1;
        @(negedge clk);

        // Empty cache misses everything.
        for (int n = 0; n < 20; n++) begin
            apb_xfer(1'($urandom), tag_t'($urandom), index_t'($urandom),
                     word_off_t'($urandom), $urandom, strb_t'($urandom), hit);
        end
        refill(tag_t'($urandom), 3'd0, rand_block());
        u_chk.end_test("reset");

        refill(tag_a, 3'd1, rand_block());
        for (int k = 0; k < 8; k++) apb_xfer(1'b0, tag_a, 3'd1, word_off_t'(k), '0, '0, hit);
        u_chk.end_test("refill");

        for (int n = 0; n < 16; n++) begin
            apb_xfer(1'b1, tag_a, 3'd1, word_off_t'($urandom), $urandom, strb_t'($urandom), hit);
        end
        for (int k = 0; k < 8; k++) apb_xfer(1'b0, tag_a, 3'd1, word_off_t'(k), '0, '0, hit);
        // The written line ages out and shows up dirty.
        for (int k = 1; k <= 4; k++) refill(tag_pool[k], 3'd1, rand_block());
        u_chk.end_test("strobes");

        for (int k = 0; k < 4; k++) refill(tag_pool[k], 3'd5, rand_block());
        apb_xfer(1'b1, tag_pool[2], 3'd5, word_off_t'($urandom), $urandom, 4'hf, hit);
        apb_xfer(1'b0, tag_pool[0], 3'd5, word_off_t'($urandom), '0, '0, hit);
        apb_xfer(1'b0, tag_pool[3], 3'd5, word_off_t'($urandom), '0, '0, hit);
        apb_xfer(1'b0, tag_pool[1], 3'd5, word_off_t'($urandom), '0, '0, hit);
        refill(tag_pool[4], 3'd5, rand_block());
        u_chk.end_test("eviction");

        // Refill raised in an access cycle must wait for the next setup cycle.
        fork
            begin
                for (int k = 1; k <= 4; k++) begin
                    apb_xfer(1'b0, tag_pool[k], 3'd1, word_off_t'($urandom), '0, '0, hit);
                end
            end
            begin
                @(negedge clk);
                refill(tag_pool[5], 3'd6, rand_block());
            end
        join
        for (int k = 0; k < 8; k++) apb_xfer(1'b0, tag_pool[5], 3'd6, word_off_t'(k), '0, '0, hit);
        u_chk.end_test("backpress");

        for (int n = 0; n < RAND_OPS; n++) begin
            tag = tag_pool[$urandom_range(5)];
            idx = index_t'($urandom);
            apb_xfer(1'($urandom), tag, idx, word_off_t'($urandom), $urandom,
                     strb_t'($urandom), hit);
            if (!hit) refill(tag, idx, rand_block());
        end
        u_chk.end_test("random");

        u_chk.report(DUT.u_assert.n_fail);
        if (u_chk.n_errors == 0 && DUT.u_assert.n_fail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+.
cache_geom_pkg.sv
cache_bus_pkg.sv
cache_tag_store.sv
cache_lru.sv
cache_data_store.sv
cache_ctrl.sv
data_cache_top.sv
cache_assert.sv
cache_checker.sv
tb_data_cache.sv
